//--- design/isa_pkg.sv
package isa_pkg;

   ////////////////////
   // widths and sizes
   ////////////////////

   // data and instruction width
   localparam int word_w = 16;
   // byte address, bit 0 ignored
   localparam int mem_addr_w = 10;
   // words per memory
   localparam int mem_words = 2 ** (mem_addr_w - 1);
   localparam int reg_cnt = 8;
   localparam int reg_addr_w = $clog2(reg_cnt);

   // instruction field widths
   localparam int opcode_w = 4;
   localparam int imm6_w = 6;
   localparam int imm9_w = 9;
   localparam int imm12_w = 12;

   ////////////////////
   // instruction set
   ////////////////////

   // opcode sits in instr[15:12]
   // rd [11:9], rs [8:6], rt [5:3]
   typedef enum logic [opcode_w-1:0] {
      op_nop  = 4'h0,
      op_add  = 4'h1,
      op_sub  = 4'h2,
      op_and  = 4'h3,
      op_xor  = 4'h4,
      op_addi = 4'h5,
      op_li   = 4'h6,
      op_ld   = 4'h7,
      op_st   = 4'h8,
      op_beqz = 4'h9,
      op_jmp  = 4'ha,
      op_halt = 4'hb
   } opcode_e;

   ////////////////////
   // shared structs
   ////////////////////

   // data memory access
   typedef struct packed {
      logic                  en;
      logic                  wr;
      logic [mem_addr_w-1:0] addr;
      logic [word_w-1:0]     wdata;
   } mem_req_t;

   // host port, sel 0 = instr mem, 1 = data mem
   typedef struct packed {
      logic                  sel;
      logic                  we;
      logic [mem_addr_w-1:0] addr;
      logic [word_w-1:0]     wdata;
   } host_req_t;

   // fetch to execute
   typedef struct packed {
      logic                  valid;
      logic [mem_addr_w-1:0] pc;
      logic [word_w-1:0]     instr;
   } fetch_t;

   // execute back to fetch
   typedef struct packed {
      logic                  taken;
      logic [mem_addr_w-1:0] target;
      logic                  halt;
   } redirect_t;

   // register write
   typedef struct packed {
      logic                  en;
      logic [reg_addr_w-1:0] rd;
      logic [word_w-1:0]     data;
   } wb_t;

endpackage

//--- design/instr_mem.sv
module instr_mem import isa_pkg::*; (
   input  logic                  clk,
   // core side read port
   input  logic [mem_addr_w-1:0] addr,
   output logic [word_w-1:0]     rdata,
   // host side write port
   input  logic                  we,
   input  logic [mem_addr_w-1:0] waddr,
   input  logic [word_w-1:0]     wdata
);

   ////////////////////
   // storage
   ////////////////////

   // one entry per 16-bit word
   logic [word_w-1:0] mem [mem_words];

   // word index, byte address bit 0 dropped
   logic [mem_addr_w-2:0] rd_idx;
   logic [mem_addr_w-2:0] wr_idx;

   assign rd_idx = addr[mem_addr_w-1:1];
   assign wr_idx = waddr[mem_addr_w-1:1];

   // combinational read, no latency
   assign rdata = mem[rd_idx];

   // program load lands at the edge
   always_ff @(posedge clk) begin
      if (we) begin
         mem[wr_idx] <= wdata;
      end
   end

   ////////////////////
   // checks
   ////////////////////

   // host load must carry a known address
   a_we_addr_known : assert property (@(posedge clk) we |-> !$isunknown(waddr))
      else $error("instr_mem write with unknown address");

endmodule

//--- design/data_mem.sv
module data_mem import isa_pkg::*; (
   input  logic              clk,
   input  mem_req_t          req,
   output logic [word_w-1:0] rdata
);

   ////////////////////
   // storage
   ////////////////////

   logic [word_w-1:0] mem [mem_words];

   // word index, odd addresses alias the even word
   logic [mem_addr_w-2:0] idx;
   logic                  rd_en;
   logic                  wr_en;

   assign idx = req.addr[mem_addr_w-1:1];

   // read only on an enabled non-write request
   assign rd_en = req.en & ~req.wr;
   assign wr_en = req.en & req.wr;

   // zero when idle or writing
   assign rdata = rd_en ? mem[idx] : '0;

   // store lands at the rising edge
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[idx] <= req.wdata;
      end
   end

   ////////////////////
   // checks
   ////////////////////

   // core or host request, address must resolve
   a_req_addr_known : assert property (
      @(posedge clk) req.en |-> !$isunknown(req.addr)
   ) else $error("data_mem request with unknown address");

   // write data must be known too
   a_wdata_known : assert property (@(posedge clk) wr_en |-> !$isunknown(req.wdata))
      else $error("data_mem write with unknown data");

endmodule

//--- design/fetch_unit.sv
module fetch_unit import isa_pkg::*; (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run,
   input  redirect_t             redirect,
   output logic [mem_addr_w-1:0] imem_addr,
   input  logic [word_w-1:0]     imem_rdata,
   output fetch_t                fetch,
   output logic                  halted
);

   ////////////////////
   // pc and halt latch
   ////////////////////

   logic [mem_addr_w-1:0] pc;
   logic [mem_addr_w-1:0] pc_next;
   // core steps only while running and not halted
   logic                  active;

   assign active = run & ~halted;

   // sequential or redirected
   assign pc_next = redirect.taken ? redirect.target : pc + mem_addr_w'(2);

   always_ff @(posedge clk) begin
      if (rst) begin
         pc     <= '0;
         halted <= 1'b0;
      end else if (active) begin
         if (redirect.halt) begin
            // pc stays on the halt word
            halted <= 1'b1;
         end else begin
            pc <= pc_next;
         end
      end
   end

   ////////////////////
   // fetch packet
   ////////////////////

   assign imem_addr = pc;

   // valid low freezes execute outputs
   assign fetch.valid = active;
   assign fetch.pc    = pc;
   assign fetch.instr = imem_rdata;

   ////////////////////
   // checks
   ////////////////////

   // targets from execute keep word alignment
   a_pc_aligned : assert property (@(posedge clk) disable iff (rst) pc[0] == 1'b0)
      else $error("pc lost word alignment");

endmodule

//--- design/reg_file.sv
module reg_file import isa_pkg::*; (
   input  logic                  clk,
   input  logic                  rst,
   // two read ports
   input  logic [reg_addr_w-1:0] rs_addr,
   input  logic [reg_addr_w-1:0] rt_addr,
   output logic [word_w-1:0]     rs_data,
   output logic [word_w-1:0]     rt_data,
   // one write port
   input  wb_t                   wb
);

   ////////////////////
   // registers
   ////////////////////

   // no storage behind r0
   logic [word_w-1:0] regs [1:reg_cnt-1];

   // writes to r0 are dropped
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 1; i < reg_cnt; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.en && wb.rd != '0) begin
         regs[wb.rd] <= wb.data;
      end
   end

   // combinational reads with r0 forced to zero
   assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
   assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

   ////////////////////
   // checks
   ////////////////////

   // decoder must hand over a resolved destination
   a_wb_rd_known : assert property (@(posedge clk) disable iff (rst) wb.en |-> !$isunknown(wb.rd))
      else $error("register write with unknown rd");

endmodule

//--- design/execute_unit.sv
module execute_unit import isa_pkg::*; (
   input  fetch_t                fetch,
   // register file read ports
   output logic [reg_addr_w-1:0] rs_addr,
   output logic [reg_addr_w-1:0] rt_addr,
   input  logic [word_w-1:0]     rs_data,
   input  logic [word_w-1:0]     rt_data,
   // data memory
   output mem_req_t              dmem_req,
   input  logic [word_w-1:0]     dmem_rdata,
   // writeback and redirect
   output wb_t                   wb,
   output redirect_t             redirect
);

   ////////////////////
   // decode
   ////////////////////

   opcode_e               op;
   logic [reg_addr_w-1:0] rd;
   logic [word_w-1:0]     imm6_sx;
   logic [word_w-1:0]     imm9_sx;
   logic [word_w-1:0]     imm12_sx;
   logic [word_w-1:0]     mem_addr_full;
   logic [mem_addr_w-1:0] pc_plus2;
   logic [mem_addr_w-1:0] br_target;
   logic [mem_addr_w-1:0] jmp_target;

   // values 12..15 fall to default below
   assign op = opcode_e'(fetch.instr[15:12]);
   assign rd = fetch.instr[11:9];

   // all immediates sign-extended to word
   assign imm6_sx  = {{(word_w-imm6_w){fetch.instr[imm6_w-1]}}, fetch.instr[imm6_w-1:0]};
   assign imm9_sx  = {{(word_w-imm9_w){fetch.instr[imm9_w-1]}}, fetch.instr[imm9_w-1:0]};
   assign imm12_sx = {{(word_w-imm12_w){fetch.instr[imm12_w-1]}}, fetch.instr[imm12_w-1:0]};

   // register operands, st reads its data from rd
   always_comb begin
      rs_addr = '0;
      rt_addr = '0;
      if (fetch.valid) begin
         rs_addr = fetch.instr[8:6];
         rt_addr = (op == op_st) ? rd : fetch.instr[5:3];
      end
   end

   ////////////////////
   // address paths
   ////////////////////

   // base plus offset
   assign mem_addr_full = rs_data + imm6_sx;

   // offsets count words from pc + 2
   assign pc_plus2   = fetch.pc + mem_addr_w'(2);
   assign br_target  = pc_plus2 + imm6_sx[mem_addr_w-2:0] * mem_addr_w'(2);
   assign jmp_target = pc_plus2 + imm12_sx[mem_addr_w-2:0] * mem_addr_w'(2);

   // memory request kept apart from the ld writeback path
   always_comb begin
      dmem_req = '0;
      if (fetch.valid && (op == op_ld || op == op_st)) begin
         dmem_req.en    = 1'b1;
         dmem_req.wr    = (op == op_st);
         dmem_req.addr  = mem_addr_full[mem_addr_w-1:0];
         dmem_req.wdata = rt_data;
      end
   end

   ////////////////////
   // alu and control
   ////////////////////

   always_comb begin
      wb       = '0;
      redirect = '0;
      wb.rd    = rd;
      if (fetch.valid) begin
         case (op)
            op_add: begin
               wb.en   = 1'b1;
               wb.data = rs_data + rt_data;
            end
            op_sub: begin
               wb.en   = 1'b1;
               wb.data = rs_data - rt_data;
            end
            op_and: begin
               wb.en   = 1'b1;
               wb.data = rs_data & rt_data;
            end
            op_xor: begin
               wb.en   = 1'b1;
               wb.data = rs_data ^ rt_data;
            end
            op_addi: begin
               wb.en   = 1'b1;
               wb.data = rs_data + imm6_sx;
            end
            op_li: begin
               wb.en   = 1'b1;
               wb.data = imm9_sx;
            end
            // load data returns same cycle
            op_ld: begin
               wb.en   = 1'b1;
               wb.data = dmem_rdata;
            end
            op_beqz: begin
               redirect.taken  = (rs_data == '0);
               redirect.target = br_target;
            end
            op_jmp: begin
               redirect.taken  = 1'b1;
               redirect.target = jmp_target;
            end
            op_halt: redirect.halt = 1'b1;
            // nop, st and unknown opcodes write no register
            default: ;
         endcase
      end
      if (!wb.en) begin
         wb.rd = '0;
      end
   end

endmodule

//--- design/cpu_top.sv
module cpu_top import isa_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic              run,
   input  host_req_t         host,
   output logic [word_w-1:0] host_rdata,
   output logic              halted
);

   fetch_t                fetch;
   redirect_t             redirect;
   wb_t                   wb;
   mem_req_t              core_req;
   mem_req_t              host_req;
   mem_req_t              dmem_req;
   logic [mem_addr_w-1:0] fetch_addr;
   logic [mem_addr_w-1:0] imem_addr;
   logic [word_w-1:0]     imem_rdata;
   logic [word_w-1:0]     dmem_rdata;
   logic                  imem_we;
   logic [reg_addr_w-1:0] rs_addr;
   logic [reg_addr_w-1:0] rt_addr;
   logic [word_w-1:0]     rs_data;
   logic [word_w-1:0]     rt_data;

   ////////////////////
   // host arbitration
   ////////////////////

   // host owns the memories only while stopped
   assign imem_we   = ~run & host.we & ~host.sel;
   assign imem_addr = run ? fetch_addr : host.addr;

   assign host_req.en    = ~run & host.sel;
   assign host_req.wr    = host.we;
   assign host_req.addr  = host.addr;
   assign host_req.wdata = host.wdata;

   assign dmem_req = run ? core_req : host_req;

   // zero while the core runs
   assign host_rdata = run ? '0 : (host.sel ? dmem_rdata : imem_rdata);

   ////////////////////
   // core
   ////////////////////

   fetch_unit u_fetch (.clk, .rst, .run, .redirect, .imem_addr(fetch_addr), .imem_rdata, .fetch,
      .halted);
   instr_mem u_imem (.clk, .addr(imem_addr), .rdata(imem_rdata), .we(imem_we),
      .waddr(host.addr), .wdata(host.wdata));
   reg_file u_regs (.clk, .rst, .rs_addr, .rt_addr, .rs_data, .rt_data, .wb);
   execute_unit u_exec (.fetch, .rs_addr, .rt_addr, .rs_data, .rt_data, .dmem_req(core_req),
      .dmem_rdata, .wb, .redirect);
   data_mem u_dmem (.clk, .req(dmem_req), .rdata(dmem_rdata));

   // host writes are dropped while running
   a_no_host_write_run : assert property (@(posedge clk) disable iff (rst) run |-> !host.we)
      else $error("host write while core running");

endmodule

//--- tests/tb_cpu.sv
module tb_cpu import isa_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int clk_period  = 20;
   localparam int test_cnt    = 6;
   localparam int cycle_limit = 300;

   logic              clk;
   logic              rst;
   logic              run;
   host_req_t         host;
   logic [word_w-1:0] host_rdata;
   logic              halted;

   int                seed = 32'h0aac3fd1;
   int                errors;
   int                checks;
   // words for the next program load, word 0 at address 0
   logic [word_w-1:0] prog [$];
   // sentinel kept from the halt test for the reset test
   logic [word_w-1:0] freeze_mark;

   cpu_top DUT (.clk, .rst, .run, .host, .host_rdata, .halted);

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   ////////////////////
   // instruction encoders
   ////////////////////

   // opcode, rd, rs, rt, three spare bits
   function automatic logic [15:0] enc_rrr(opcode_e op, int rd, int rs, int rt);
      return {op, rd[2:0], rs[2:0], rt[2:0], 3'b000};
   endfunction

   // addi, ld, st, beqz
   function automatic logic [15:0] enc_imm6(opcode_e op, int rd, int rs, int imm);
      return {op, rd[2:0], rs[2:0], imm[5:0]};
   endfunction

   function automatic logic [15:0] enc_li(int rd, int imm);
      return {op_li, rd[2:0], imm[8:0]};
   endfunction

   // offset in words from pc + 2
   function automatic logic [15:0] enc_jmp(int off);
      return {op_jmp, off[11:0]};
   endfunction

   ////////////////////
   // host side tasks
   ////////////////////

   task automatic compare_word(input string what, input logic [15:0] got, input logic [15:0] want);
      checks++;
      if (got !== want) begin
         errors++;
         $display("ERROR at %0t ns: %s expected %h got %h", $time, what, want, got);
      end
   endtask

   // strobe high for exactly one cycle
   task automatic host_write(input logic sel, input int addr, input logic [15:0] data);
      @(negedge clk);
      host.sel   = sel;
      host.we    = 1'b1;
      host.addr  = addr[mem_addr_w-1:0];
      host.wdata = data;
      @(negedge clk);
      host.we = 1'b0;
   endtask

   // read is combinational, sampled at the next rising edge
   task automatic host_read(input logic sel, input int addr, output logic [15:0] data);
      @(negedge clk);
      host.sel  = sel;
      host.we   = 1'b0;
      host.addr = addr[mem_addr_w-1:0];
      @(posedge clk);
      data = host_rdata;
   endtask

   task automatic check_dmem(input int addr, input logic [15:0] want, input string what);
      logic [15:0] got;
      host_read(1'b1, addr, got);
      compare_word(what, got, want);
   endtask

   task automatic load_program();
      for (int i = 0; i < prog.size(); i++) begin
         host_write(1'b0, 2 * i, prog[i]);
      end
   endtask

   task automatic apply_reset();
      @(negedge clk);
      rst = 1'b1;
      repeat (5) @(negedge clk);
      rst = 1'b0;
   endtask

   // hold keeps run high for extra cycles after halted rises
   task automatic run_until_halt(input int hold);
      int cyc;
      cyc = 0;
      @(negedge clk);
      run = 1'b1;
      while (!halted && cyc < cycle_limit) begin
         @(negedge clk);
         cyc++;
      end
      if (!halted) begin
         errors++;
         $display("core did not halt within %0d cycles at %0t ns", cycle_limit, $time);
      end else begin
         repeat (hold) @(negedge clk);
      end
      run = 1'b0;
   endtask

   ////////////////////
   // directed tests
   ////////////////////

   task automatic test_host_access();
      logic [9:0]  a [8];
      logic [15:0] iw [8];
      logic [15:0] dw [8];
      logic [15:0] got;
      int          i;
      for (i = 0; i < 8; i++) begin
         // one word per 64 byte block, so no two entries collide
         a[i]  = 10'(i * 64 + ($random(seed) & 15) * 2);
         iw[i] = 16'($random(seed));
         dw[i] = 16'($random(seed));
         host_write(1'b0, a[i] | (i % 2), iw[i]);
         host_write(1'b1, a[i] | ((i + 1) % 2), dw[i]);
      end
      // odd address aliases its even neighbor
      for (i = 0; i < 8; i++) begin
         host_read(1'b0, a[i], got);
         compare_word("imem even read", got, iw[i]);
         host_read(1'b0, a[i] | 1, got);
         compare_word("imem odd read", got, iw[i]);
         check_dmem(a[i], dw[i], "dmem even read");
         check_dmem(a[i] | 1, dw[i], "dmem odd read");
      end
   endtask

   task automatic test_alu();
      logic [15:0] x;
      logic [15:0] y;
      logic [5:0]  imm;
      logic [15:0] imm_sx;
      x      = 16'($random(seed));
      y      = 16'($random(seed));
      imm    = 6'($random(seed));
      imm_sx = {{10{imm[5]}}, imm};
      host_write(1'b1, 128, x);
      host_write(1'b1, 130, y);
      prog.delete();
      prog.push_back(enc_li(7, 128));
      prog.push_back(enc_imm6(op_ld, 1, 7, 0));
      prog.push_back(enc_imm6(op_ld, 2, 7, 2));
      prog.push_back(enc_rrr(op_add, 3, 1, 2));
      prog.push_back(enc_imm6(op_st, 3, 7, 4));
      prog.push_back(enc_rrr(op_sub, 3, 1, 2));
      prog.push_back(enc_imm6(op_st, 3, 7, 6));
      prog.push_back(enc_rrr(op_and, 3, 1, 2));
      prog.push_back(enc_imm6(op_st, 3, 7, 8));
      prog.push_back(enc_rrr(op_xor, 3, 1, 2));
      prog.push_back(enc_imm6(op_st, 3, 7, 10));
      prog.push_back(enc_imm6(op_addi, 3, 1, imm));
      prog.push_back(enc_imm6(op_st, 3, 7, 12));
      prog.push_back({op_halt, 12'h000});
      load_program();
      apply_reset();
      run_until_halt(0);
      check_dmem(132, x + y, "add result");
      check_dmem(134, x - y, "sub result");
      check_dmem(136, x & y, "and result");
      check_dmem(138, x ^ y, "xor result");
      check_dmem(140, x + imm_sx, "addi result");
   endtask

   task automatic test_li_r0();
      // nonzero first, so a zero store shows up
      host_write(1'b1, 164, 16'hffff);
      prog.delete();
      prog.push_back(enc_li(7, 160));
      prog.push_back(enc_li(1, -200));
      prog.push_back(enc_imm6(op_st, 1, 7, 0));
      prog.push_back(enc_li(2, 173));
      prog.push_back(enc_imm6(op_st, 2, 7, 2));
      prog.push_back(enc_li(0, 55));
      prog.push_back(enc_imm6(op_st, 0, 7, 4));
      prog.push_back({op_halt, 12'h000});
      load_program();
      apply_reset();
      run_until_halt(0);
      check_dmem(160, 16'(-200), "li negative");
      check_dmem(162, 16'd173, "li positive");
      check_dmem(164, 16'h0000, "r0 after write");
   endtask

   task automatic test_branch();
      int n;
      n = 5 + ($random(seed) & 15);
      host_write(1'b1, 192, 16'h0000);
      host_write(1'b1, 194, 16'h0000);
      prog.delete();
      prog.push_back(enc_li(7, 192));
      prog.push_back(enc_li(1, n));
      prog.push_back(enc_li(2, 0));
      // word 3, loop head, exits to word 7
      prog.push_back(enc_imm6(op_beqz, 0, 1, 3));
      prog.push_back(enc_rrr(op_add, 2, 2, 1));
      prog.push_back(enc_imm6(op_addi, 1, 1, -1));
      prog.push_back(enc_jmp(-4));
      prog.push_back(enc_imm6(op_st, 2, 7, 0));
      prog.push_back(enc_li(3, 9));
      // not taken, else the store below is skipped
      prog.push_back(enc_imm6(op_beqz, 0, 3, 1));
      prog.push_back(enc_imm6(op_st, 3, 7, 2));
      prog.push_back({op_halt, 12'h000});
      load_program();
      apply_reset();
      run_until_halt(0);
      check_dmem(192, 16'(n * (n + 1) / 2), "countdown sum");
      check_dmem(194, 16'd9, "beqz fall through");
   endtask

   task automatic test_halt_freeze();
      freeze_mark = 16'($random(seed));
      host_write(1'b1, 224, 16'h0000);
      host_write(1'b1, 226, freeze_mark);
      prog.delete();
      prog.push_back(enc_li(7, 224));
      prog.push_back(enc_li(1, 77));
      prog.push_back(enc_imm6(op_st, 1, 7, 0));
      prog.push_back({op_halt, 12'h000});
      // must never execute
      prog.push_back(enc_imm6(op_st, 1, 7, 2));
      load_program();
      apply_reset();
      run_until_halt(20);
      checks++;
      if (halted !== 1'b1) begin
         errors++;
         $display("ERROR at %0t ns: halted fell while run stayed high", $time);
      end
      check_dmem(224, 16'd77, "store before halt");
      check_dmem(226, freeze_mark, "store after halt");
   endtask

   task automatic test_reset();
      int k;
      // r1 and r7 still hold values from the halt test
      apply_reset();
      checks++;
      if (halted !== 1'b0) begin
         errors++;
         $display("ERROR at %0t ns: halted still high after reset", $time);
      end
      prog.delete();
      for (k = 0; k < reg_cnt; k++) begin
         host_write(1'b1, 2 * k, 16'ha5a0 | 16'(k));
         prog.push_back(enc_imm6(op_st, k, 0, 2 * k));
      end
      prog.push_back({op_halt, 12'h000});
      load_program();
      run_until_halt(0);
      for (k = 0; k < reg_cnt; k++) begin
         check_dmem(2 * k, 16'h0000, $sformatf("r%0d after reset", k));
      end
      check_dmem(224, 16'd77, "dmem kept over reset");
      check_dmem(226, freeze_mark, "sentinel kept over reset");
   endtask

   ////////////////////
   // sequence and report
   ////////////////////

   initial begin
      rst    = 1'b1;
      run    = 1'b0;
      host   = '0;
      errors = 0;
      checks = 0;
      apply_reset();
      test_host_access();
      test_alu();
      test_li_r0();
      test_branch();
      test_halt_freeze();
      test_reset();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   // every test limited to cycle_limit run cycles
   initial begin
      #(test_cnt * cycle_limit * clk_period);
      $display("watchdog expired before the tests finished");
      $display("sim failed");
      $finish;
   end

endmodule

//--- src.f
design/isa_pkg.sv
design/instr_mem.sv
design/data_mem.sv
design/fetch_unit.sv
design/reg_file.sv
design/execute_unit.sv
design/cpu_top.sv
tests/tb_cpu.sv
